// File: common/icache_pkg.sv
`default_nettype none

package icache_pkg;

    // cache geometry
    localparam int unsigned WAY_NUM     = 2;
    localparam int unsigned LINE_BEATS  = 8;
    localparam int unsigned BEAT_BITS   = $clog2(LINE_BEATS);
    localparam int unsigned OFFSET_BITS = 5;
    localparam int unsigned PAIR_LSB    = 3;
    localparam int unsigned TAG_BITS    = 32 - OFFSET_BITS;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;

    // low word holds the lower address
    typedef logic [63:0] inst_pair_t;

    // full line address, stored as the tag
    typedef logic [TAG_BITS-1:0] line_tag_t;

    typedef logic [OFFSET_BITS-PAIR_LSB-1:0] pair_idx_t;

    typedef logic [WAY_NUM-1:0] way_vec_t;

    typedef enum logic [1:0] {
        CACOP_INDEX_INV = 2'd0,
        CACOP_HIT_INV   = 2'd1
    } cacop_op_e;

endpackage

`default_nettype wire

// File: icache/tag_array.sv
`default_nettype none

module tag_array import icache_pkg::*; #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic     clk,
    input  logic     rst_n,
    input  addr_t    lookup_addr_i,
    input  addr_t    maint_addr_i,
    input  way_vec_t tag_we_i,
    input  logic     tag_valid_i,
    input  addr_t    refill_addr_i,
    output way_vec_t fetch_hit_o,
    output way_vec_t cacop_hit_o
);

    localparam int unsigned SET_BITS = $clog2(SET_NUM);

    line_tag_t           tag_mem [WAY_NUM][SET_NUM];
    logic [SET_NUM-1:0]  valid_q [WAY_NUM];
    line_tag_t           lookup_tag_q [WAY_NUM];
    line_tag_t           maint_tag_q [WAY_NUM];
    way_vec_t            lookup_vld_q;
    way_vec_t            maint_vld_q;
    line_tag_t           lookup_line_q;
    line_tag_t           maint_line_q;
    logic [SET_BITS-1:0] lookup_set;
    logic [SET_BITS-1:0] maint_set;
    logic [SET_BITS-1:0] wr_set;

    assign lookup_set = lookup_addr_i[OFFSET_BITS +: SET_BITS];
    assign maint_set  = maint_addr_i[OFFSET_BITS +: SET_BITS];

    // refill writes set valid, maintenance clears it
    assign wr_set = tag_valid_i ? refill_addr_i[OFFSET_BITS +: SET_BITS] : maint_set;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int w = 0; w < WAY_NUM; w++) begin
                valid_q[w] <= '0;
            end
            lookup_vld_q <= '0;
            maint_vld_q  <= '0;
        end else begin
            for (int w = 0; w < WAY_NUM; w++) begin
                lookup_vld_q[w] <= valid_q[w][lookup_set];
                maint_vld_q[w]  <= valid_q[w][maint_set];
                if (tag_we_i[w]) begin
                    valid_q[w][wr_set] <= tag_valid_i;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        lookup_line_q <= lookup_addr_i[31:OFFSET_BITS];
        maint_line_q  <= maint_addr_i[31:OFFSET_BITS];
        for (int w = 0; w < WAY_NUM; w++) begin
            lookup_tag_q[w] <= tag_mem[w][lookup_set];
            maint_tag_q[w]  <= tag_mem[w][maint_set];
            if (tag_we_i[w] && tag_valid_i) begin
                tag_mem[w][wr_set] <= refill_addr_i[31:OFFSET_BITS];
            end
        end
    end

    always_comb begin
        for (int w = 0; w < WAY_NUM; w++) begin
            fetch_hit_o[w] = lookup_vld_q[w] && (lookup_tag_q[w] == lookup_line_q);
            cacop_hit_o[w] = maint_vld_q[w] && (maint_tag_q[w] == maint_line_q);
        end
    end

endmodule

`default_nettype wire

// File: icache/data_array.sv
`default_nettype none

module data_array import icache_pkg::*; #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic       clk,
    input  addr_t      lookup_addr_i,
    input  way_vec_t   fetch_hit_i,
    input  logic       wr_en_i,
    input  way_vec_t   wr_way_i,
    input  addr_t      wr_set_addr_i,
    input  pair_idx_t  wr_pair_i,
    input  inst_pair_t wr_data_i,
    output inst_pair_t hit_insts_o
);

    localparam int unsigned SET_BITS = $clog2(SET_NUM);
    localparam int unsigned ROW_BITS = SET_BITS + $bits(pair_idx_t);
    localparam int unsigned ROWS     = 1 << ROW_BITS;

    inst_pair_t          pair_mem [WAY_NUM][ROWS];
    inst_pair_t          rd_pair_q [WAY_NUM];
    logic [ROW_BITS-1:0] rd_row;
    logic [ROW_BITS-1:0] wr_row;

    // set and pair bits sit next to each other in the address
    assign rd_row = lookup_addr_i[PAIR_LSB +: ROW_BITS];
    assign wr_row = {wr_set_addr_i[OFFSET_BITS +: SET_BITS], wr_pair_i};

    always_ff @(posedge clk) begin
        for (int w = 0; w < WAY_NUM; w++) begin
            rd_pair_q[w] <= pair_mem[w][rd_row];
            if (wr_en_i && wr_way_i[w]) begin
                pair_mem[w][wr_row] <= wr_data_i;
            end
        end
    end

    // on a miss the output is ignored
    assign hit_insts_o = fetch_hit_i[1] ? rd_pair_q[1] : rd_pair_q[0];

endmodule

`default_nettype wire

// File: icache/refill_buffer.sv
`default_nettype none

module refill_buffer import icache_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       start_i,
    input  addr_t      req_addr_i,
    input  logic       mem_data_valid_i,
    input  word_t      mem_data_i,
    output logic       wr_en_o,
    output pair_idx_t  wr_pair_o,
    output inst_pair_t wr_data_o,
    output logic       refill_done_o,
    output inst_pair_t refill_insts_o
);

    logic [BEAT_BITS-1:0] beat_q;
    word_t                even_q;
    logic                 wr_en_q;
    logic                 done_q;
    pair_idx_t            wr_pair_q;
    inst_pair_t           wr_data_q;
    inst_pair_t           insts_q;
    pair_idx_t            beat_pair;

    assign beat_pair = beat_q[BEAT_BITS-1:1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            beat_q  <= '0;
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            wr_en_q <= 1'b0;
            done_q  <= 1'b0;
            if (start_i) begin
                beat_q <= '0;
            end else if (mem_data_valid_i) begin
                beat_q <= beat_q + 1'b1;
                // odd beat completes a pair
                if (beat_q[0]) begin
                    wr_en_q <= 1'b1;
                    done_q  <= (beat_q == BEAT_BITS'(LINE_BEATS - 1));
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mem_data_valid_i) begin
            if (!beat_q[0]) begin
                even_q <= mem_data_i;
            end else begin
                wr_pair_q <= beat_pair;
                wr_data_q <= {mem_data_i, even_q};
                // keep the pair the fetch asked for
                if (beat_pair == req_addr_i[PAIR_LSB +: $bits(pair_idx_t)]) begin
                    insts_q <= {mem_data_i, even_q};
                end
            end
        end
    end

    assign wr_en_o        = wr_en_q;
    assign wr_pair_o      = wr_pair_q;
    assign wr_data_o      = wr_data_q;
    assign refill_done_o  = done_q;
    assign refill_insts_o = insts_q;

endmodule

`default_nettype wire

// File: icache/icache_ctrl.sv
`default_nettype none

module icache_ctrl import icache_pkg::*; #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush_i,
    input  logic       fetch_valid_i,
    input  addr_t      fetch_addr_i,
    output logic       fetch_ready_o,
    input  logic       commit_req_valid_i,
    input  cacop_op_e  cacop_op_i,
    input  addr_t      cacop_addr_i,
    output logic       commit_ready_o,
    output logic       commit_resp_valid_o,
    input  logic       mem_req_ready_i,
    output logic       mem_req_valid_o,
    output addr_t      mem_req_addr_o,
    input  way_vec_t   fetch_hit_i,
    input  way_vec_t   cacop_hit_i,
    input  inst_pair_t hit_insts_i,
    input  logic       refill_done_i,
    input  inst_pair_t refill_insts_i,
    output logic       resp_valid_o,
    output addr_t      resp_addr_o,
    output inst_pair_t resp_insts_o,
    output addr_t      lookup_addr_o,
    output addr_t      maint_addr_o,
    output way_vec_t   tag_we_o,
    output logic       tag_valid_o,
    output way_vec_t   refill_way_o,
    output logic       refill_start_o
);

    localparam int unsigned SET_BITS = $clog2(SET_NUM);

    typedef enum logic [1:0] {
        S_IDLE,
        S_MISS_REQ,
        S_MISS_DATA,
        S_HIT_INV_WR
    } icache_state_e;

    icache_state_e       state_q;
    icache_state_e       state_d;
    logic                lookup_valid_q;
    addr_t               lookup_addr_q;
    addr_t               cacop_addr_q;
    logic                flushed_q;
    logic                commit_resp_q;
    logic [SET_NUM-1:0]  victim_q;
    logic [SET_BITS-1:0] lookup_set;
    logic                fetch_fire;
    logic                commit_fire;
    logic                index_inv_fire;
    logic                hit;
    logic                miss;

    assign lookup_set = lookup_addr_q[OFFSET_BITS +: SET_BITS];

    // a flushed lookup is neither a hit nor a miss
    assign hit  = lookup_valid_q && (|fetch_hit_i) && !flush_i;
    assign miss = lookup_valid_q && !(|fetch_hit_i) && !flush_i;

    // maintenance takes priority over fetch
    assign fetch_ready_o  = (state_q == S_IDLE) && !miss && !commit_req_valid_i;
    assign commit_ready_o = (state_q == S_IDLE) && !lookup_valid_q;

    assign fetch_fire     = fetch_valid_i && fetch_ready_o;
    assign commit_fire    = commit_req_valid_i && commit_ready_o;
    assign index_inv_fire = commit_fire && (cacop_op_i == CACOP_INDEX_INV);

    // arrays read the raw fetch address and compare next cycle
    assign lookup_addr_o = fetch_addr_i;

    assign resp_addr_o    = {lookup_addr_q[31:PAIR_LSB], {PAIR_LSB{1'b0}}};
    assign mem_req_addr_o = {lookup_addr_q[31:OFFSET_BITS], {OFFSET_BITS{1'b0}}};
    assign refill_way_o   = victim_q[lookup_set] ? 2'b10 : 2'b01;
    assign refill_start_o = mem_req_valid_o && mem_req_ready_i;

    assign commit_resp_valid_o = commit_resp_q;

    always_comb begin
        state_d         = state_q;
        mem_req_valid_o = 1'b0;
        resp_valid_o    = 1'b0;
        resp_insts_o    = hit_insts_i;
        tag_we_o        = '0;
        tag_valid_o     = 1'b0;
        maint_addr_o    = cacop_addr_i;
        case (state_q)
            S_IDLE: begin
                resp_valid_o = hit;
                if (miss) begin
                    mem_req_valid_o = 1'b1;
                    state_d = mem_req_ready_i ? S_MISS_DATA : S_MISS_REQ;
                end else if (commit_fire) begin
                    if (cacop_op_i == CACOP_HIT_INV) begin
                        state_d = S_HIT_INV_WR;
                    end else begin
                        // address bit 0 picks the way
                        tag_we_o = cacop_addr_i[0] ? 2'b10 : 2'b01;
                    end
                end
            end
            S_MISS_REQ: begin
                mem_req_valid_o = 1'b1;
                if (mem_req_ready_i) begin
                    state_d = S_MISS_DATA;
                end
            end
            S_MISS_DATA: begin
                if (refill_done_i) begin
                    tag_we_o     = refill_way_o;
                    tag_valid_o  = 1'b1;
                    resp_valid_o = !flushed_q && !flush_i;
                    resp_insts_o = refill_insts_i;
                    state_d      = S_IDLE;
                end
            end
            S_HIT_INV_WR: begin
                // tags were read in the accept cycle
                maint_addr_o = cacop_addr_q;
                tag_we_o     = cacop_hit_i;
                state_d      = S_IDLE;
            end
            default: begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q        <= S_IDLE;
            lookup_valid_q <= 1'b0;
            flushed_q      <= 1'b0;
            commit_resp_q  <= 1'b0;
            victim_q       <= '0;
        end else begin
            state_q        <= state_d;
            lookup_valid_q <= fetch_fire;
            commit_resp_q  <= index_inv_fire || (state_q == S_HIT_INV_WR);
            if (state_q == S_IDLE) begin
                flushed_q <= 1'b0;
            end else if (flush_i) begin
                flushed_q <= 1'b1;
            end
            if (state_q == S_MISS_DATA && refill_done_i) begin
                victim_q[lookup_set] <= !victim_q[lookup_set];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            lookup_addr_q <= fetch_addr_i;
        end
        if (commit_fire) begin
            cacop_addr_q <= cacop_addr_i;
        end
    end

endmodule

`default_nettype wire

// File: icache/icache_top.sv
`default_nettype none

module icache_top import icache_pkg::*; #(
    parameter int unsigned SET_NUM = 128
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       flush_i,
    input  logic       fetch_valid_i,
    input  addr_t      fetch_addr_i,
    output logic       fetch_ready_o,
    output logic       resp_valid_o,
    output addr_t      resp_addr_o,
    output inst_pair_t resp_insts_o,
    output logic       mem_req_valid_o,
    output addr_t      mem_req_addr_o,
    input  logic       mem_req_ready_i,
    input  logic       mem_data_valid_i,
    input  word_t      mem_data_i,
    input  logic       commit_req_valid_i,
    input  cacop_op_e  cacop_op_i,
    input  addr_t      cacop_addr_i,
    output logic       commit_ready_o,
    output logic       commit_resp_valid_o
);

    addr_t      lookup_addr;
    addr_t      maint_addr;
    way_vec_t   fetch_hit;
    way_vec_t   cacop_hit;
    way_vec_t   tag_we;
    logic       tag_valid;
    way_vec_t   refill_way;
    logic       refill_start;
    logic       refill_done;
    inst_pair_t refill_insts;
    inst_pair_t hit_insts;
    logic       data_we;
    pair_idx_t  data_pair;
    inst_pair_t data_wdata;

    icache_ctrl #(
        .SET_NUM(SET_NUM)
    ) ctrl_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush_i            (flush_i),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_addr_i       (fetch_addr_i),
        .fetch_ready_o      (fetch_ready_o),
        .commit_req_valid_i (commit_req_valid_i),
        .cacop_op_i         (cacop_op_i),
        .cacop_addr_i       (cacop_addr_i),
        .commit_ready_o     (commit_ready_o),
        .commit_resp_valid_o(commit_resp_valid_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .fetch_hit_i        (fetch_hit),
        .cacop_hit_i        (cacop_hit),
        .hit_insts_i        (hit_insts),
        .refill_done_i      (refill_done),
        .refill_insts_i     (refill_insts),
        .resp_valid_o       (resp_valid_o),
        .resp_addr_o        (resp_addr_o),
        .resp_insts_o       (resp_insts_o),
        .lookup_addr_o      (lookup_addr),
        .maint_addr_o       (maint_addr),
        .tag_we_o           (tag_we),
        .tag_valid_o        (tag_valid),
        .refill_way_o       (refill_way),
        .refill_start_o     (refill_start)
    );

    // the registered pair address in resp_addr_o also steers the refill
    tag_array #(
        .SET_NUM(SET_NUM)
    ) tag_inst (
        .clk          (clk),
        .rst_n        (rst_n),
        .lookup_addr_i(lookup_addr),
        .maint_addr_i (maint_addr),
        .tag_we_i     (tag_we),
        .tag_valid_i  (tag_valid),
        .refill_addr_i(resp_addr_o),
        .fetch_hit_o  (fetch_hit),
        .cacop_hit_o  (cacop_hit)
    );

    data_array #(
        .SET_NUM(SET_NUM)
    ) data_inst (
        .clk          (clk),
        .lookup_addr_i(lookup_addr),
        .fetch_hit_i  (fetch_hit),
        .wr_en_i      (data_we),
        .wr_way_i     (refill_way),
        .wr_set_addr_i(resp_addr_o),
        .wr_pair_i    (data_pair),
        .wr_data_i    (data_wdata),
        .hit_insts_o  (hit_insts)
    );

    refill_buffer refill_inst (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (refill_start),
        .req_addr_i      (resp_addr_o),
        .mem_data_valid_i(mem_data_valid_i),
        .mem_data_i      (mem_data_i),
        .wr_en_o         (data_we),
        .wr_pair_o       (data_pair),
        .wr_data_o       (data_wdata),
        .refill_done_o   (refill_done),
        .refill_insts_o  (refill_insts)
    );

endmodule

`default_nettype wire

// File: bench/icache_checker.sv
`default_nettype none

module icache_checker import icache_pkg::*; (
    input wire logic      clk,
    input wire logic      rst_n,
    input wire logic      fetch_ready_i,
    input wire logic      resp_valid_i,
    input wire logic      mem_req_valid_i,
    input wire logic      mem_req_ready_i,
    input wire logic      refill_done_i,
    input wire logic      commit_req_valid_i,
    input wire logic      commit_ready_i,
    input wire cacop_op_e cacop_op_i,
    input wire logic      commit_resp_valid_i
);

    logic commit_fire;

    assign commit_fire = commit_req_valid_i && commit_ready_i;

    assert property (@(posedge clk) disable iff (!rst_n)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i)
        else $error("memory request dropped before it was accepted");

    // after a stall only a refill may answer
    assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid_i && !$past(fetch_ready_i) |-> refill_done_i)
        else $error("response after a stall without a refill");

    assert property (@(posedge clk) disable iff (!rst_n)
        commit_fire && cacop_op_i == CACOP_INDEX_INV |=> commit_resp_valid_i)
        else $error("index invalidate not answered in one cycle");

    assert property (@(posedge clk) disable iff (!rst_n)
        commit_fire && cacop_op_i == CACOP_HIT_INV |=> ##1 commit_resp_valid_i)
        else $error("hit invalidate not answered in two cycles");

endmodule

bind icache_top icache_checker checker_inst (
    .clk                (clk),
    .rst_n              (rst_n),
    .fetch_ready_i      (fetch_ready_o),
    .resp_valid_i       (resp_valid_o),
    .mem_req_valid_i    (mem_req_valid_o),
    .mem_req_ready_i    (mem_req_ready_i),
    .refill_done_i      (refill_done),
    .commit_req_valid_i (commit_req_valid_i),
    .commit_ready_i     (commit_ready_o),
    .cacop_op_i         (cacop_op_i),
    .commit_resp_valid_i(commit_resp_valid_o)
);

`default_nettype wire

// File: bench/icache_tb.sv
`default_nettype none

module icache_tb import icache_pkg::*;;

    localparam int unsigned SET_NUM = 128;
    // under 30 fetches and maintenance ops of well below 100 cycles each
    localparam int TIMEOUT_CYCLES = 4000;
    localparam word_t MEM_KEY = 32'h5A5A0000;

    logic       clk;
    logic       rst_n;
    logic       flush_i;
    logic       fetch_valid_i;
    addr_t      fetch_addr_i;
    logic       fetch_ready_o;
    logic       resp_valid_o;
    addr_t      resp_addr_o;
    inst_pair_t resp_insts_o;
    logic       mem_req_valid_o;
    addr_t      mem_req_addr_o;
    logic       mem_req_ready_i = 1'b0;
    logic       mem_data_valid_i = 1'b0;
    word_t      mem_data_i = '0;
    logic       commit_req_valid_i;
    cacop_op_e  cacop_op_i;
    addr_t      cacop_addr_i;
    logic       commit_ready_o;
    logic       commit_resp_valid_o;

    int         error_count = 0;
    int         cycle_count = 0;
    int         seed = 99;
    logic       mem_busy = 1'b0;
    addr_t      mem_line = '0;
    int         mem_beat = 0;
    int         accept_delay = 0;

    icache_top #(
        .SET_NUM(SET_NUM)
    ) icache_top_inst (
        .clk                (clk),
        .rst_n              (rst_n),
        .flush_i            (flush_i),
        .fetch_valid_i      (fetch_valid_i),
        .fetch_addr_i       (fetch_addr_i),
        .fetch_ready_o      (fetch_ready_o),
        .resp_valid_o       (resp_valid_o),
        .resp_addr_o        (resp_addr_o),
        .resp_insts_o       (resp_insts_o),
        .mem_req_valid_o    (mem_req_valid_o),
        .mem_req_addr_o     (mem_req_addr_o),
        .mem_req_ready_i    (mem_req_ready_i),
        .mem_data_valid_i   (mem_data_valid_i),
        .mem_data_i         (mem_data_i),
        .commit_req_valid_i (commit_req_valid_i),
        .cacop_op_i         (cacop_op_i),
        .cacop_addr_i       (cacop_addr_i),
        .commit_ready_o     (commit_ready_o),
        .commit_resp_valid_o(commit_resp_valid_o)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    // memory model with a random accept delay and random gaps between beats
    always @(negedge clk) begin
        if (!rst_n) begin
            mem_req_ready_i  = 1'b0;
            mem_data_valid_i = 1'b0;
            mem_busy         = 1'b0;
            accept_delay     = 2;
        end else if (!mem_busy) begin
            mem_data_valid_i = 1'b0;
            if (mem_req_ready_i) begin
                // request taken at the last rising edge
                mem_req_ready_i = 1'b0;
                mem_busy        = 1'b1;
                mem_beat        = 0;
                accept_delay    = $random(seed) & 3;
            end else if (mem_req_valid_o) begin
                if (accept_delay == 0) begin
                    mem_req_ready_i = 1'b1;
                    mem_line        = mem_req_addr_o;
                end else begin
                    accept_delay--;
                end
            end
        end else if (($random(seed) & 3) != 0) begin
            mem_data_valid_i = 1'b1;
            mem_data_i       = (mem_line + addr_t'(4 * mem_beat)) ^ MEM_KEY;
            mem_beat++;
            if (mem_beat == LINE_BEATS) begin
                mem_busy = 1'b0;
            end
        end else begin
            mem_data_valid_i = 1'b0;
        end
    end

    function automatic inst_pair_t expected_pair(input addr_t addr);
        addr_t base;
        base = {addr[31:3], 3'b000};
        return {(base + 32'd4) ^ MEM_KEY, base ^ MEM_KEY};
    endfunction

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("** Error: %s = %h, expected %h", name, got, exp);
        error_count++;
    endtask

    task automatic report_failure(input string what);
        $display("error: %s", what);
        error_count++;
    endtask

    task automatic check_response(input addr_t addr);
        if (resp_valid_o !== 1'b1) begin
            report_mismatch("resp_valid_o", resp_valid_o, 1);
        end
        if (resp_addr_o !== {addr[31:3], 3'b000}) begin
            report_mismatch("resp_addr_o", resp_addr_o, {addr[31:3], 3'b000});
        end
        if (resp_insts_o !== expected_pair(addr)) begin
            report_mismatch("resp_insts_o", resp_insts_o, expected_pair(addr));
        end
    endtask

    // outputs are sampled 10 units after the falling edge
    task automatic do_fetch(input addr_t addr, input bit expect_hit);
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addr;
        #10;
        while (!fetch_ready_o) begin
            @(negedge clk);
            #10;
        end
        @(negedge clk);
        fetch_valid_i = 1'b0;
        #10;
        if (expect_hit) begin
            if (mem_req_valid_o !== 1'b0) begin
                report_mismatch("mem_req_valid_o", mem_req_valid_o, 0);
            end
            check_response(addr);
        end else begin
            if (resp_valid_o !== 1'b0) begin
                report_mismatch("resp_valid_o", resp_valid_o, 0);
            end
            if (mem_req_valid_o !== 1'b1) begin
                report_mismatch("mem_req_valid_o", mem_req_valid_o, 1);
            end
            if (mem_req_addr_o !== {addr[31:5], 5'b00000}) begin
                report_mismatch("mem_req_addr_o", mem_req_addr_o, {addr[31:5], 5'b00000});
            end
            do begin
                @(negedge clk);
                #10;
            end while (!resp_valid_o);
            check_response(addr);
        end
    endtask

    task automatic do_cacop(input cacop_op_e op, input addr_t addr, input int latency);
        int cycles;
        @(negedge clk);
        commit_req_valid_i = 1'b1;
        cacop_op_i         = op;
        cacop_addr_i       = addr;
        #10;
        while (!commit_ready_o) begin
            @(negedge clk);
            #10;
        end
        @(negedge clk);
        commit_req_valid_i = 1'b0;
        #10;
        cycles = 1;
        while (!commit_resp_valid_o && cycles < 8) begin
            @(negedge clk);
            #10;
            cycles++;
        end
        if (cycles != latency) begin
            report_mismatch("commit_resp_valid_o latency", cycles, latency);
        end
    endtask

    task automatic test_miss_then_hit();
        do_fetch(32'h0000_0104, 1'b0);
        do_fetch(32'h0000_0100, 1'b1);
        do_fetch(32'h0000_0108, 1'b1);
        do_fetch(32'h0000_0114, 1'b1);
        do_fetch(32'h0000_0118, 1'b1);
    endtask

    task automatic test_stream_and_flush();
        addr_t addrs [4];
        addrs = '{32'h0000_0100, 32'h0000_0108, 32'h0000_0110, 32'h0000_011C};
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_addr_i  = addrs[0];
        #10;
        for (int i = 0; i < 4; i++) begin
            if (!fetch_ready_o) begin
                report_failure("fetch stalled during a hit stream");
            end
            @(negedge clk);
            if (i < 3) begin
                fetch_addr_i = addrs[i+1];
            end else begin
                fetch_valid_i = 1'b0;
            end
            #10;
            check_response(addrs[i]);
        end
        // flush lands in the lookup cycle
        @(negedge clk);
        fetch_valid_i = 1'b1;
        fetch_addr_i  = 32'h0000_0108;
        @(negedge clk);
        fetch_valid_i = 1'b0;
        flush_i       = 1'b1;
        #10;
        if (resp_valid_o !== 1'b0) begin
            report_mismatch("resp_valid_o", resp_valid_o, 0);
        end
        @(negedge clk);
        flush_i = 1'b0;
        #10;
        if (resp_valid_o !== 1'b0 || mem_req_valid_o !== 1'b0) begin
            report_failure("flushed fetch still produced a response or request");
        end
    endtask

    task automatic test_replacement();
        do_fetch(32'h0000_1200, 1'b0);
        do_fetch(32'h0000_2208, 1'b0);
        do_fetch(32'h0000_3210, 1'b0);
        do_fetch(32'h0000_2200, 1'b1);
        do_fetch(32'h0000_1218, 1'b0);
    endtask

    task automatic test_index_inv();
        do_fetch(32'h0000_1300, 1'b0);
        do_fetch(32'h0000_2300, 1'b0);
        do_cacop(CACOP_INDEX_INV, 32'h0000_0301, 1);
        do_fetch(32'h0000_1308, 1'b1);
        do_fetch(32'h0000_2308, 1'b0);
    endtask

    task automatic test_hit_inv();
        do_fetch(32'h0000_1400, 1'b0);
        do_fetch(32'h0000_2400, 1'b0);
        do_cacop(CACOP_HIT_INV, 32'h0000_1400, 2);
        do_fetch(32'h0000_1410, 1'b0);
        do_cacop(CACOP_HIT_INV, 32'h0000_5400, 2);
        do_fetch(32'h0000_1400, 1'b1);
        do_fetch(32'h0000_2418, 1'b1);
    endtask

    initial begin
        clk                = 1'b0;
        rst_n              = 1'b0;
        flush_i            = 1'b0;
        fetch_valid_i      = 1'b0;
        fetch_addr_i       = '0;
        commit_req_valid_i = 1'b0;
        cacop_op_i         = CACOP_INDEX_INV;
        cacop_addr_i       = '0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #10;
        if (fetch_ready_o !== 1'b1 || commit_ready_o !== 1'b1) begin
            report_failure("ready outputs not high after reset");
        end
        if (resp_valid_o !== 1'b0 || commit_resp_valid_o !== 1'b0 ||
            mem_req_valid_o !== 1'b0) begin
            report_failure("valid outputs not low after reset");
        end
        test_miss_then_hit();
        test_stream_and_flush();
        test_replacement();
        test_index_inv();
        test_hit_inv();
        repeat (4) @(negedge clk);
        $display("errors: %0d", error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
common/icache_pkg.sv
icache/tag_array.sv
icache/data_array.sv
icache/refill_buffer.sv
icache/icache_ctrl.sv
icache/icache_top.sv
bench/icache_checker.sv
bench/icache_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = icache_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | awk '{ print } /^NO ERRORS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)
